// File: Makefile
# Verilator flow for the pipeline: lint, simulate, clean

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f pipe_top.f --top-module pipe_top

sim:
	verilator --binary --timing -f pipe_top.f --top-module pipe_top_tb -o pipe_top_sim
	./obj_dir/pipe_top_sim | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: pipe_top.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/stage_if.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/pipe_top.sv
verification/pipe_top_tb.sv

// File: rtl/decode_stage.sv
// Decode stage
//   Instruction decode and source use flags
//   Register file, r0 reads as zero, write-first bypass from write-back
//   Execute stage register, bubble when stalled or idle
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defs.svh"

module decode_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     instr_valid,
  input  instr_t   instr,
  input  logic     stall,
  output reg_idx_t src1,
  output reg_idx_t src2,
  output logic     uses_src1,
  output logic     uses_src2,
  stage_if.consumer wb,
  stage_if.producer ex
);

  data_t    regs [`PIPE_REG_COUNT];
  decoded_t dec;
  logic     wb_we;
  logic     accept;

  // Instruction leaves decode only when not held by the hazard unit
  assign accept = instr_valid && !stall;

  // Write-back to r0 is dropped
  assign wb_we = wb.valid && wb.writes_reg && (wb.dst != '0);

  always_comb
  begin
    src1 = instr.rs1;
    // STORE takes its data from the rd field
    src2 = (instr.opcode == OP_STORE) ? instr.rd : instr.operand.r.rs2;

    dec.opcode     = instr.opcode;
    dec.dst        = instr.rd;
    dec.imm        = {{(`PIPE_DATA_WIDTH-$bits(imm_t)){instr.operand.imm[5]}},
                      instr.operand.imm};
    dec.writes_reg = 1'b0;
    dec.is_load    = 1'b0;
    uses_src1      = 1'b0;
    uses_src2      = 1'b0;

    case (instr.opcode)
      OP_ADD, OP_SUB, OP_AND, OP_XOR:
      begin
        uses_src1      = 1'b1;
        uses_src2      = 1'b1;
        dec.writes_reg = 1'b1;
      end
      OP_ADDI:
      begin
        uses_src1      = 1'b1;
        dec.writes_reg = 1'b1;
      end
      OP_LOAD:
      begin
        uses_src1      = 1'b1;
        dec.writes_reg = 1'b1;
        dec.is_load    = 1'b1;
      end
      OP_STORE:
      begin
        uses_src1 = 1'b1;
        uses_src2 = 1'b1;
      end
      // Unused encodings behave as NOP
      default:
      begin
        dec.opcode = OP_NOP;
      end
    endcase

    // Writing r0 is architecturally a no-op
    if (instr.rd == '0)
    begin
      dec.writes_reg = 1'b0;
    end

    // Register read, a same-cycle write-back wins
    if (src1 == '0)
      dec.src1_val = '0;
    else if (wb_we && (wb.dst == src1))
      dec.src1_val = wb.payload.data;
    else
      dec.src1_val = regs[src1];

    if (src2 == '0)
      dec.src2_val = '0;
    else if (wb_we && (wb.dst == src2))
      dec.src2_val = wb.payload.data;
    else
      dec.src2_val = regs[src2];
  end

  // Register file write port
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `PIPE_REG_COUNT; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wb_we)
    begin
      regs[wb.dst] <= wb.payload.data;
    end
  end

  // Execute stage register control
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ex.valid      <= 1'b0;
      ex.dst        <= '0;
      ex.writes_reg <= 1'b0;
    end
    else
    begin
      // Bubble unless an instruction is accepted
      ex.valid      <= accept;
      ex.dst        <= dec.dst;
      ex.writes_reg <= accept && dec.writes_reg;
    end
  end

  // Payload is qualified by valid
  always_ff @(posedge clk)
  begin
    ex.payload.opcode   <= dec.opcode;
    ex.payload.src1_val <= dec.src1_val;
    ex.payload.src2_val <= dec.src2_val;
    ex.payload.imm      <= dec.imm;
    ex.payload.is_load  <= dec.is_load;
  end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
// Execute stage
//   ALU for ADD, SUB, AND, XOR, ADDI
//   Address generation rs1 + imm for LOAD and STORE
//   Memory stage register
`timescale 1ns/1ps
`default_nettype none

module execute_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  stage_if.consumer ex,
  stage_if.producer mem
);

  data_t alu_result;

  always_comb
  begin
    case (ex.payload.opcode)
      OP_ADD:  alu_result = ex.payload.src1_val + ex.payload.src2_val;
      OP_SUB:  alu_result = ex.payload.src1_val - ex.payload.src2_val;
      OP_AND:  alu_result = ex.payload.src1_val & ex.payload.src2_val;
      OP_XOR:  alu_result = ex.payload.src1_val ^ ex.payload.src2_val;
      // Immediate add, also the effective address
      OP_ADDI, OP_LOAD, OP_STORE:
        alu_result = ex.payload.src1_val + ex.payload.imm;
      default: alu_result = '0;
    endcase
  end

  // Control fields carry straight through
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      mem.valid      <= 1'b0;
      mem.dst        <= '0;
      mem.writes_reg <= 1'b0;
    end
    else
    begin
      mem.valid      <= ex.valid;
      mem.dst        <= ex.dst;
      mem.writes_reg <= ex.valid && ex.writes_reg;
    end
  end

  always_ff @(posedge clk)
  begin
    mem.payload.result     <= alu_result;
    // Store data comes from the second source
    mem.payload.store_data <= ex.payload.src2_val;
    mem.payload.is_load    <= ex.payload.is_load;
    mem.payload.is_store   <= (ex.payload.opcode == OP_STORE);
  end

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
// Hazard detection unit
//   Data hazard against the execute stage
//   Load-use hazard against the memory stage
//   Combinational stall level back to decode and the instruction source
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
  import isa_pkg::*;
(
  input  reg_idx_t src1,
  input  reg_idx_t src2,
  input  logic     uses_src1,
  input  logic     uses_src2,
  input  logic     instr_valid,
  stage_if.monitor ex,
  stage_if.monitor mem,
  output logic     stall
);

  logic ex_hit;
  logic mem_hit;

  // One source against one in-flight producer
  // r0 never conflicts, and only valid writing items count
  function automatic logic src_conflict(input logic used, input reg_idx_t src,
                                        input logic prod_valid, input logic prod_writes,
                                        input reg_idx_t prod_dst);
    return used && (src != '0) && prod_valid && prod_writes && (src == prod_dst);
  endfunction

  // Producer still in execute
  assign ex_hit = src_conflict(uses_src1, src1, ex.valid, ex.writes_reg, ex.dst) ||
                  src_conflict(uses_src2, src2, ex.valid, ex.writes_reg, ex.dst);

  // Producer in memory, covers loads whose data is not yet read
  assign mem_hit = src_conflict(uses_src1, src1, mem.valid, mem.writes_reg, mem.dst) ||
                   src_conflict(uses_src2, src2, mem.valid, mem.writes_reg, mem.dst);

  // Nothing presented means nothing to hold
  assign stall = instr_valid && (ex_hit || mem_hit);

endmodule

`default_nettype wire

// File: rtl/isa_pkg.sv
// ISA package
//   opcode_t, reg_idx_t, data_t, imm_t
//   instr_t with its register and immediate operand forms
//   decoded_t, the decode stage result
`default_nettype none

`include "pipe_defs.svh"

package isa_pkg;

  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_ADD   = 4'd1,
    OP_SUB   = 4'd2,
    OP_AND   = 4'd3,
    OP_XOR   = 4'd4,
    OP_ADDI  = 4'd5,
    OP_LOAD  = 4'd6,
    OP_STORE = 4'd7
  } opcode_t;

  typedef logic [2:0] reg_idx_t;
  typedef logic [`PIPE_DATA_WIDTH-1:0] data_t;
  typedef logic signed [5:0] imm_t;

  // Register form of the low six bits
  typedef struct packed {
    reg_idx_t   rs2;
    logic [2:0] spare;
  } rs2_field_t;

  // Low six bits hold either rs2 or the immediate
  typedef union packed {
    rs2_field_t r;
    imm_t       imm;
  } operand_t;

  // STORE uses the rd field as the store data source
  typedef struct packed {
    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    operand_t operand;
  } instr_t;

  typedef struct packed {
    opcode_t  opcode;
    reg_idx_t dst;
    data_t    src1_val;
    data_t    src2_val;
    data_t    imm;
    logic     writes_reg;
    logic     is_load;
  } decoded_t;

endpackage

`default_nettype wire

// File: rtl/memory_stage.sv
// Memory stage
//   Data memory, synchronous write and combinational read
//   Write-back register, load data or ALU result
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defs.svh"

module memory_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  stage_if.consumer mem,
  stage_if.producer wb
);

  localparam int ADDR_W = $clog2(`PIPE_MEM_DEPTH);

  data_t              ram [`PIPE_MEM_DEPTH];
  logic [ADDR_W-1:0]  addr;
  data_t              rdata;
  logic               store_en;

  // Address wraps modulo the memory depth
  assign addr     = mem.payload.result[ADDR_W-1:0];
  assign rdata    = ram[addr];
  assign store_en = mem.valid && mem.payload.is_store;

  // Memory starts out cleared
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `PIPE_MEM_DEPTH; i++)
      begin
        ram[i] <= '0;
      end
    end
    else if (store_en)
    begin
      ram[addr] <= mem.payload.store_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wb.valid      <= 1'b0;
      wb.dst        <= '0;
      wb.writes_reg <= 1'b0;
    end
    else
    begin
      wb.valid      <= mem.valid;
      wb.dst        <= mem.dst;
      // A store leaves as a non-writing item
      wb.writes_reg <= mem.valid && mem.writes_reg && !mem.payload.is_store;
    end
  end

  // Load data replaces the address
  always_ff @(posedge clk)
  begin
    wb.payload.data <= mem.payload.is_load ? rdata : mem.payload.result;
  end

endmodule

`default_nettype wire

// File: rtl/pipe_defs.svh
// Global sizing macros for the integer pipeline
//   PIPE_DATA_WIDTH  register and memory word size
//   PIPE_REG_COUNT   architectural register count
//   PIPE_MEM_DEPTH   data memory words
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// Word size shared by the register file, ALU and data memory
`define PIPE_DATA_WIDTH 16

// Eight registers, so a register index is 3 bits wide
`define PIPE_REG_COUNT 8

// Data memory depth in words
// Addresses wrap modulo this depth
`define PIPE_MEM_DEPTH 64

`endif

// File: rtl/pipe_pkg.sv
// Stage boundary payloads
//   ex_payload_t   decode to execute
//   mem_payload_t  execute to memory
//   wb_payload_t   memory to write-back
`default_nettype none

package pipe_pkg;

  import isa_pkg::*;

  // Operands and operation, indices travel on the bus itself
  typedef struct packed {
    opcode_t opcode;
    data_t   src1_val;
    data_t   src2_val;
    data_t   imm;
    logic    is_load;
  } ex_payload_t;

  // ALU result doubles as the memory address for LOAD and STORE
  typedef struct packed {
    data_t result;
    data_t store_data;
    logic  is_load;
    logic  is_store;
  } mem_payload_t;

  // Word written back into the register file
  typedef struct packed {
    data_t data;
  } wb_payload_t;

endpackage

`default_nettype wire

// File: rtl/pipe_top.sv
// Pipeline top level
//   Decode, execute and memory stages joined by three stage_if boundaries
//   Hazard unit producing the stall level
//   Retire port driven from write-back
`timescale 1ns/1ps
`default_nettype none

module pipe_top
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     instr_valid,
  input  instr_t   instr,
  output logic     stall,
  output logic     retire_valid,
  output reg_idx_t retire_dst,
  output data_t    retire_data
);

  reg_idx_t src1;
  reg_idx_t src2;
  logic     uses_src1;
  logic     uses_src2;

  // Stage boundaries, one payload type each
  stage_if #(.payload_t(ex_payload_t))  ex_bus  ();
  stage_if #(.payload_t(mem_payload_t)) mem_bus ();
  stage_if #(.payload_t(wb_payload_t))  wb_bus  ();

  decode_stage decode_stage_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .stall       (stall),
    .src1        (src1),
    .src2        (src2),
    .uses_src1   (uses_src1),
    .uses_src2   (uses_src2),
    .wb          (wb_bus.consumer),
    .ex          (ex_bus.producer)
  );

  hazard_unit hazard_unit_i (
    .src1        (src1),
    .src2        (src2),
    .uses_src1   (uses_src1),
    .uses_src2   (uses_src2),
    .instr_valid (instr_valid),
    .ex          (ex_bus.monitor),
    .mem         (mem_bus.monitor),
    .stall       (stall)
  );

  execute_stage execute_stage_i (
    .clk   (clk),
    .rst_n (rst_n),
    .ex    (ex_bus.consumer),
    .mem   (mem_bus.producer)
  );

  memory_stage memory_stage_i (
    .clk   (clk),
    .rst_n (rst_n),
    .mem   (mem_bus.consumer),
    .wb    (wb_bus.producer)
  );

  // Only register writes other than r0 retire
  assign retire_valid = wb_bus.valid && wb_bus.writes_reg;
  assign retire_dst   = wb_bus.dst;
  assign retire_data  = wb_bus.payload.data;

endmodule

`default_nettype wire

// File: rtl/stage_if.sv
// Stage boundary interface
//   Payload type is a parameter so one definition serves all three boundaries
//   producer, consumer and monitor modports
`timescale 1ns/1ps
`default_nettype none

interface stage_if
  import isa_pkg::*;
#(
  parameter type payload_t = logic
) ();

  // Item present on this boundary
  logic     valid;
  // Destination register and whether it gets written
  reg_idx_t dst;
  logic     writes_reg;
  payload_t payload;

  // Driving stage, always from a register
  modport producer (output valid, output dst, output writes_reg, output payload);

  // Next stage, samples on the following edge
  modport consumer (input valid, input dst, input writes_reg, input payload);

  // Observer only, used by the hazard unit
  modport monitor (input valid, input dst, input writes_reg, input payload);

endinterface

`default_nettype wire

// File: verification/pipe_top_tb.sv
// Testbench for the integer pipeline
//   Clock, reset and falling-edge instruction driver
//   ISA reference model with an expected retire queue
//   Retire comparator, stall checks and cycle watchdog
//   Directed tests for ALU, hazards, load/store and r0, then random programs
`timescale 1ns/1ps
`default_nettype none

module pipe_top_tb
  import isa_pkg::*;
();

  localparam int NUM_DIRECTED = 24;
  localparam int NUM_RANDOM = 200;
  localparam int NUM_INSTR = NUM_DIRECTED + NUM_RANDOM;
  // Issue and drain plus worst-case stalls per instruction with margin for reset
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 3 + NUM_INSTR * 3 + 50;

  logic     clk;
  logic     rst_n;
  logic     instr_valid;
  instr_t   instr;
  logic     stall;
  logic     retire_valid;
  reg_idx_t retire_dst;
  data_t    retire_data;

  // Architectural model state
  logic [15:0] model_regs [8];
  logic [15:0] model_mem [64];
  reg_idx_t    exp_dst_q [$];
  data_t       exp_data_q [$];

  int    exp_count = 0;
  int    retire_count = 0;
  int    retire_errors = 0;
  int    stall_errors = 0;
  int    other_errors = 0;
  int    cycles = 0;
  int    seed;
  string current_test = "reset";

  pipe_top pipe_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .stall        (stall),
    .retire_valid (retire_valid),
    .retire_dst   (retire_dst),
    .retire_data  (retire_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Register form holds opcode, rd, rs1 and rs2 from the top, then three spare bits
  function automatic instr_t rtype(input opcode_t op, input reg_idx_t rd,
                                   input reg_idx_t rs1, input reg_idx_t rs2);
    return instr_t'({op, rd, rs1, rs2, 3'b000});
  endfunction

  // Immediate form keeps the signed immediate in the low six bits
  function automatic instr_t itype(input opcode_t op, input reg_idx_t rd,
                                   input reg_idx_t rs1, input int imm);
    return instr_t'({op, rd, rs1, imm[5:0]});
  endfunction

  // Executes one instruction on the model and queues its expected retire
  function automatic void exec_instr(input logic [15:0] word);
    logic [3:0]  op;
    logic [2:0]  rd;
    logic [2:0]  rs1;
    logic [2:0]  rs2;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] imm;
    logic [15:0] addr;
    logic [15:0] res;
    logic        wr;
    op   = word[15:12];
    rd   = word[11:9];
    rs1  = word[8:6];
    rs2  = word[5:3];
    imm  = {{10{word[5]}}, word[5:0]};
    a    = model_regs[rs1];
    b    = model_regs[rs2];
    addr = a + imm;
    res  = 16'h0000;
    wr   = 1'b1;
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_XOR:  res = a ^ b;
      OP_ADDI: res = a + imm;
      OP_LOAD: res = model_mem[addr[5:0]];
      OP_STORE:
      begin
        // Store data is named by the rd field
        model_mem[addr[5:0]] = model_regs[rd];
        wr = 1'b0;
      end
      default: wr = 1'b0;
    endcase
    // r0 stays zero and never retires
    if (wr && rd != 3'd0)
    begin
      model_regs[rd] = res;
      exp_dst_q.push_back(rd);
      exp_data_q.push_back(res);
      exp_count++;
    end
  endfunction

  task automatic check_retire(input string name, input reg_idx_t exp_dst,
                              input data_t exp_data, input reg_idx_t act_dst,
                              input data_t act_data);
    if (act_dst !== exp_dst || act_data !== exp_data)
    begin
      retire_errors++;
      $display("FAIL %s: expected r%0d=%h, got r%0d=%h",
               name, exp_dst, exp_data, act_dst, act_data);
    end
  endtask

  task automatic check_stall(input string name, input logic exp_stall, input logic act_stall);
    if (act_stall !== exp_stall)
    begin
      stall_errors++;
      $display("FAIL %s: stall expected %b, got %b at cycle %0d",
               name, exp_stall, act_stall, cycles);
    end
  endtask

  // Starts on a falling edge and returns on the falling edge after acceptance
  // A negative exp_stalls skips the stall checks
  task automatic issue(input instr_t word, input int exp_stalls);
    int   n = 0;
    logic accepted = 1'b0;
    instr_valid = 1'b1;
    instr       = word;
    while (!accepted)
    begin
      // Look at stall once the presented word has settled
      #1;
      if (exp_stalls >= 0)
        check_stall(current_test, logic'(n < exp_stalls), stall);
      if (stall)
      begin
        n++;
        @(negedge clk);
      end
      else
        accepted = 1'b1;
    end
    exec_instr(word);
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  // Waits until every queued retire has shown up and the pipe is empty
  task automatic drain();
    while (exp_dst_q.size() != 0)
      @(negedge clk);
    repeat (3) @(negedge clk);
  endtask

  // Each retire is matched against the oldest expected write
  always @(negedge clk)
  begin
    if (rst_n && retire_valid)
    begin
      retire_count = retire_count + 1;
      if (exp_dst_q.size() == 0)
      begin
        other_errors++;
        $display("Unexpected retire of r%0d in %s with nothing outstanding",
                 retire_dst, current_test);
      end
      else
        check_retire(current_test, exp_dst_q.pop_front(), exp_data_q.pop_front(),
                     retire_dst, retire_data);
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, the pipeline did not finish", cycles);
      $display("tests failed");
      $finish;
    end
  end

  initial
  begin
    logic [31:0] raw;
    seed        = 32'hdcf2;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = instr_t'(16'h0000);
    for (int i = 0; i < 8; i++)
      model_regs[i] = 16'h0000;
    for (int i = 0; i < 64; i++)
      model_mem[i] = 16'h0000;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Seed r1..r7 from r0 without any stall
    current_test = "seed";
    for (int k = 1; k < 8; k++)
      issue(itype(OP_ADDI, reg_idx_t'(k), 3'd0, k * 7 - 20), 0);
    drain();

    // Independent ALU ops with no source in flight
    current_test = "alu_ops";
    issue(rtype(OP_ADD, 3'd1, 3'd2, 3'd3), 0);
    issue(rtype(OP_SUB, 3'd4, 3'd5, 3'd6), 0);
    issue(rtype(OP_AND, 3'd7, 3'd2, 3'd5), 0);
    issue(rtype(OP_XOR, 3'd3, 3'd5, 3'd6), 0);
    issue(itype(OP_ADDI, 3'd2, 3'd6, -5), 0);
    drain();

    // Producer sits in execute then memory for two stall cycles
    current_test = "back_to_back";
    issue(itype(OP_ADDI, 3'd1, 3'd2, 3), 0);
    issue(rtype(OP_ADD, 3'd3, 3'd1, 3'd4), 2);
    drain();
    // One slot apart the producer is already in memory
    current_test = "one_apart";
    issue(itype(OP_ADDI, 3'd5, 3'd6, 7), 0);
    issue(rtype(OP_XOR, 3'd7, 3'd2, 3'd4), 0);
    issue(rtype(OP_SUB, 3'd4, 3'd5, 3'd2), 1);
    drain();

    // Store r1 to r6+2, load it back and use it at once
    // Base, address and stored word all differ
    current_test = "load_use";
    issue(itype(OP_ADDI, 3'd6, 3'd0, 12), 0);
    issue(itype(OP_STORE, 3'd1, 3'd6, 2), 2);
    issue(itype(OP_LOAD, 3'd2, 3'd6, 2), 0);
    issue(rtype(OP_ADD, 3'd3, 3'd2, 3'd1), 2);
    drain();

    // r0 writes vanish and r0 reads never stall
    current_test = "reg_zero";
    issue(itype(OP_ADDI, 3'd0, 3'd1, 5), 0);
    issue(rtype(OP_ADD, 3'd4, 3'd0, 3'd0), 0);
    issue(rtype(OP_XOR, 3'd5, 3'd0, 3'd1), 0);
    drain();

    // Random words with the top bit clear keep the opcode in 0..7
    current_test = "random";
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      raw     = $random(seed);
      raw[15] = 1'b0;
      issue(instr_t'(raw[15:0]), -1);
    end
    drain();

    if (retire_count != exp_count)
    begin
      other_errors++;
      $display("FAIL retire_count: expected %0d retires, got %0d", exp_count, retire_count);
    end

    $display("Errors: %0d retire, %0d stall, %0d other",
             retire_errors, stall_errors, other_errors);
    if (retire_errors + stall_errors + other_errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire
